// File: src/isa_pkg.sv
// RV32I base integer ISA only, no M extension and no compressed encodings
// AUIPC has no operation of its own and decodes to ADD with the PC as
// first operand
package isa_pkg;

    ////////////////////////////////////////
    // Major opcodes, instruction bits 6:0
    ////////////////////////////////////////

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    ////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////

    // SYSTEM, MISC-MEM and unknown opcodes count as R
    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

    ////////////////////////////////////////
    // Operations handed to execute
    ////////////////////////////////////////

    typedef enum logic [5:0] {
        // Bubble and undecodable word
        NOP, INVALID,
        // Arithmetic and logic, register or immediate
        LUI, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        // Jumps
        JAL, JALR,
        // Branches
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // Loads
        LB, LH, LW, LBU, LHU,
        // Stores
        SB, SH, SW,
        // Privileged and system
        ECALL, EBREAK, SRET, MRET, WFI,
        // CSR access
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI
    } op_e;

endpackage

// File: src/pipe_pkg.sv
// Data types on the pipeline and register bank ports
// Widths are fixed by RV32I
package pipe_pkg;

    // One machine word, used for instruction, PC, operands and register data
    typedef logic [31:0] word_t;

    // Register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

endpackage

// File: src/decode_if.sv
// Decoded fields of the effective instruction, valid in the same cycle
// The stage reads op, format and imm straight from its own instance
interface decode_if;

    pipe_pkg::reg_addr_t rs1;
    pipe_pkg::reg_addr_t rs2;
    pipe_pkg::reg_addr_t rd;
    isa_pkg::op_e        op;
    isa_pkg::format_e    format;
    pipe_pkg::word_t     imm;

    // Operand and memory usage, for hazard checks
    logic                use_rs1;
    logic                use_rs2;
    logic                use_mem;
    logic                is_store;

    modport decoder (
        output rs1, rs2, rd, op, format, imm,
        output use_rs1, use_rs2, use_mem, is_store
    );

    modport hazard (
        input rs1, rs2, rd,
        input use_rs1, use_rs2, use_mem, is_store
    );

endinterface

// File: src/instr_decoder.sv
// Purely combinational RV32I decoder, zero cycles from word to fields
// Unknown encodings give INVALID with R format and a zero immediate
// FENCE is accepted as NOP
module instr_decoder (
    decode_if.decoder       dec,
    input pipe_pkg::word_t  instr_i
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    format_e    fmt;
    op_e        op_branch;
    op_e        op_load;
    op_e        op_store;
    op_e        op_imm;
    op_e        op_reg;
    op_e        op_system;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////
    // Operation per opcode group
    ////////////////////////////////////////

    always_comb begin
        unique case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift immediates still constrain funct7
    always_comb begin
        unique case ({funct7, funct3}) inside
            10'b???????000: op_imm = ADD;
            10'b0000000001: op_imm = SLL;
            10'b???????010: op_imm = SLT;
            10'b???????011: op_imm = SLTU;
            10'b???????100: op_imm = XOR;
            10'b0000000101: op_imm = SRL;
            10'b0100000101: op_imm = SRA;
            10'b???????110: op_imm = OR;
            10'b???????111: op_imm = AND;
            default:        op_imm = INVALID;
        endcase
    end

    always_comb begin
        unique case ({funct7, funct3})
            10'b0000000000: op_reg = ADD;
            10'b0100000000: op_reg = SUB;
            10'b0000000001: op_reg = SLL;
            10'b0000000010: op_reg = SLT;
            10'b0000000011: op_reg = SLTU;
            10'b0000000100: op_reg = XOR;
            10'b0000000101: op_reg = SRL;
            10'b0100000101: op_reg = SRA;
            10'b0000000110: op_reg = OR;
            10'b0000000111: op_reg = AND;
            default:        op_reg = INVALID;
        endcase
    end

    // Bits 31:7, privileged forms first as exact words
    always_comb begin
        unique case (instr_i[31:7]) inside
            25'b0000000000000000000000000: op_system = ECALL;
            25'b0000000000010000000000000: op_system = EBREAK;
            25'b0001000000100000000000000: op_system = SRET;
            25'b0011000000100000000000000: op_system = MRET;
            25'b0001000001010000000000000: op_system = WFI;
            25'b?????????????????001?????: op_system = CSRRW;
            25'b?????????????????010?????: op_system = CSRRS;
            25'b?????????????????011?????: op_system = CSRRC;
            25'b?????????????????101?????: op_system = CSRRWI;
            25'b?????????????????110?????: op_system = CSRRSI;
            25'b?????????????????111?????: op_system = CSRRCI;
            default:                       op_system = INVALID;
        endcase
    end

    always_comb begin
        unique case (opcode)
            OPC_LUI:      dec.op = LUI;
            OPC_AUIPC:    dec.op = ADD;
            OPC_JAL:      dec.op = JAL;
            OPC_JALR:     dec.op = (funct3 == 3'b000) ? JALR : INVALID;
            OPC_BRANCH:   dec.op = op_branch;
            OPC_LOAD:     dec.op = op_load;
            OPC_STORE:    dec.op = op_store;
            OPC_OP_IMM:   dec.op = op_imm;
            OPC_OP:       dec.op = op_reg;
            OPC_MISC_MEM: dec.op = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM:   dec.op = op_system;
            default:      dec.op = INVALID;
        endcase
    end

    ////////////////////////////////////////
    // Format and immediate
    ////////////////////////////////////////

    always_comb begin
        unique case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: fmt = I_TYPE;
            OPC_STORE:                      fmt = S_TYPE;
            OPC_BRANCH:                     fmt = B_TYPE;
            OPC_LUI, OPC_AUIPC:             fmt = U_TYPE;
            OPC_JAL:                        fmt = J_TYPE;
            default:                        fmt = R_TYPE;
        endcase
    end

    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        unique case (fmt)
            I_TYPE:  dec.imm = imm_i;
            S_TYPE:  dec.imm = imm_s;
            B_TYPE:  dec.imm = imm_b;
            U_TYPE:  dec.imm = imm_u;
            J_TYPE:  dec.imm = imm_j;
            default: dec.imm = '0;
        endcase
    end

    assign dec.format = fmt;

    // Register fields are taken whatever the format
    assign dec.rs1 = instr_i[19:15];
    assign dec.rs2 = instr_i[24:20];
    assign dec.rd  = instr_i[11:7];

    assign dec.use_rs1  = (fmt == R_TYPE) || (fmt == I_TYPE) || (fmt == S_TYPE) || (fmt == B_TYPE);
    assign dec.use_rs2  = (fmt == R_TYPE) || (fmt == S_TYPE) || (fmt == B_TYPE);
    assign dec.use_mem  = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
    assign dec.is_store = (opcode == OPC_STORE);

endmodule

// File: src/hazard_unit.sv
// One-entry lock against the instruction accepted one cycle earlier
// Older producers are not tracked and must be covered by forwarding
// Any rd is locked, even for formats that write no register
module hazard_unit (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    decode_if.hazard  hz,
    output logic      hazard_o
);
    import pipe_pkg::*;

    reg_addr_t locked_reg;
    logic      locked_mem;
    logic      hazard_rs1;
    logic      hazard_rs2;
    logic      hazard_mem;

    ////////////////////////////////////////
    // Hazard decision
    ////////////////////////////////////////

    // x0 is never a dependency
    assign hazard_rs1 = hz.use_rs1 && (hz.rs1 == locked_reg) && (hz.rs1 != '0);
    assign hazard_rs2 = hz.use_rs2 && (hz.rs2 == locked_reg) && (hz.rs2 != '0);

    // Memory access right behind a store
    assign hazard_mem = locked_mem && hz.use_mem;

    // A stalled stage issues nothing, so no bubble either
    assign hazard_o = (hazard_rs1 || hazard_rs2 || hazard_mem) && !stall_i;

    ////////////////////////////////////////
    // Lock register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || hazard_o) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
        end else if (!stall_i) begin
            locked_reg <= hz.rd;
            locked_mem <= hz.is_store;
        end
    end

endmodule

// File: src/decode_stage.sv
// RV32I decode stage, one cycle from accepted instruction to outputs
// Register bank must answer rs1/rs2 addresses in the same cycle
// Upstream holds pc_i while a stall or a hazard is being replayed
// Only one instruction in flight, hazards checked against the last one
module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    input  pipe_pkg::word_t     instr_i,
    input  pipe_pkg::word_t     pc_i,
    input  pipe_pkg::word_t     rs1_data_i,
    input  pipe_pkg::word_t     rs2_data_i,
    output pipe_pkg::reg_addr_t rs1_addr_o,
    output pipe_pkg::reg_addr_t rs2_addr_o,
    output isa_pkg::op_e        op_o,
    output pipe_pkg::reg_addr_t rd_o,
    output pipe_pkg::word_t     first_o,
    output pipe_pkg::word_t     second_o,
    output pipe_pkg::word_t     third_o,
    output pipe_pkg::word_t     pc_o,
    output logic                hazard_o,
    output logic                illegal_o,
    output logic                misaligned_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    decode_if dec ();

    word_t instr_eff;
    word_t instr_last;
    logic  replay;
    word_t first_op;
    word_t second_op;
    word_t third_op;

    ////////////////////////////////////////
    // Replay of the held instruction
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        instr_last <= instr_eff;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            replay <= 1'b0;
        end else begin
            replay <= hazard_o || stall_i;
        end
    end

    assign instr_eff = replay ? instr_last : instr_i;

    instr_decoder i_instr_decoder (
        .dec     (dec),
        .instr_i (instr_eff)
    );

    hazard_unit i_hazard_unit (
        .clk      (clk),
        .reset    (reset),
        .stall_i  (stall_i),
        .hz       (dec),
        .hazard_o (hazard_o)
    );

    assign rs1_addr_o = dec.rs1;
    assign rs2_addr_o = dec.rs2;

    ////////////////////////////////////////
    // Operand routing by format
    ////////////////////////////////////////

    always_comb begin
        unique case (dec.format)
            U_TYPE, J_TYPE: begin
                first_op  = pc_i;
                second_op = dec.imm;
                third_op  = dec.imm;
            end
            R_TYPE, B_TYPE: begin
                first_op  = rs1_data_i;
                second_op = rs2_data_i;
                third_op  = dec.imm;
            end
            // Store data travels in the third operand
            S_TYPE: begin
                first_op  = rs1_data_i;
                second_op = dec.imm;
                third_op  = rs2_data_i;
            end
            default: begin
                first_op  = rs1_data_i;
                second_op = dec.imm;
                third_op  = dec.imm;
            end
        endcase
    end

    ////////////////////////////////////////
    // Output register, bubble on hazard
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || hazard_o) begin
            op_o         <= NOP;
            rd_o         <= '0;
            first_o      <= '0;
            second_o     <= '0;
            third_o      <= '0;
            pc_o         <= '0;
            illegal_o    <= 1'b0;
            misaligned_o <= 1'b0;
        end else if (!stall_i) begin
            op_o         <= dec.op;
            rd_o         <= dec.rd;
            first_o      <= first_op;
            second_o     <= second_op;
            third_o      <= third_op;
            pc_o         <= pc_i;
            illegal_o    <= (dec.op == INVALID);
            misaligned_o <= (pc_i[1:0] != 2'b00);
        end
    end

endmodule

// File: testbench/tb_decode_stage.sv
// Random-stimulus testbench for the RV32I decode stage
// The register bank model answers rs1/rs2 addresses combinationally
// pc_i is held by the stimulus while the stage replays an instruction
// Stops at the first mismatch
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_INSTR  = 3000;
    localparam int MAX_CYCLES = NUM_INSTR * 3 + 100;
    localparam logic [6:0] OPC_TABLE [11] = '{
        OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
        OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM
    };

    logic      clk;
    logic      reset;
    logic      stall_i;
    word_t     instr_i;
    word_t     pc_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    reg_addr_t rs1_addr_o;
    reg_addr_t rs2_addr_o;
    op_e       op_o;
    reg_addr_t rd_o;
    word_t     first_o;
    word_t     second_o;
    word_t     third_o;
    word_t     pc_o;
    logic      hazard_o;
    logic      illegal_o;
    logic      misaligned_o;

    word_t       bank [32];
    logic [31:0] lfsr_state;
    reg_addr_t   last_rd;
    int          cycles = 0;

    // Expected registered outputs
    op_e       exp_op;
    reg_addr_t exp_rd;
    word_t     exp_first;
    word_t     exp_second;
    word_t     exp_third;
    word_t     exp_pc;
    logic      exp_illegal;
    logic      exp_misaligned;

    decode_stage i_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .rs1_addr_o   (rs1_addr_o),
        .rs2_addr_o   (rs2_addr_o),
        .op_o         (op_o),
        .rd_o         (rd_o),
        .first_o      (first_o),
        .second_o     (second_o),
        .third_o      (third_o),
        .pc_o         (pc_o),
        .hazard_o     (hazard_o),
        .illegal_o    (illegal_o),
        .misaligned_o (misaligned_o)
    );

    // Register bank model answering in the same cycle
    assign rs1_data_i = bank[rs1_addr_o];
    assign rs2_data_i = bank[rs2_addr_o];

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run($sformatf("timeout, run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    ////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_op(input string name, input op_e exp, input op_e act);
        if (exp !== act) begin
            stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_outputs();
        check_op("op_o", exp_op, op_o);
        check_addr("rd_o", exp_rd, rd_o);
        check_word("first_o", exp_first, first_o);
        check_word("second_o", exp_second, second_o);
        check_word("third_o", exp_third, third_o);
        check_word("pc_o", exp_pc, pc_o);
        check_flag("illegal_o", exp_illegal, illegal_o);
        check_flag("misaligned_o", exp_misaligned, misaligned_o);
    endtask

    task automatic expect_bubble();
        exp_op         = NOP;
        exp_rd         = '0;
        exp_first      = '0;
        exp_second     = '0;
        exp_third      = '0;
        exp_pc         = '0;
        exp_illegal    = 1'b0;
        exp_misaligned = 1'b0;
    endtask

    ////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Mostly legal opcodes with rs1/rs2 often aimed at the last rd
    function automatic word_t gen_instr();
        word_t      w;
        logic [3:0] idx;
        w = rand_bits(32);
        if (rand_bits(3) != 0) begin
            idx = 4'(rand_bits(4) % 11);
            w[6:0] = OPC_TABLE[idx];
            case (2'(rand_bits(2)))
                2'd0:    w[31:25] = 7'h00;
                2'd1:    w[31:25] = 7'h20;
                default: ;
            endcase
            if (w[6:0] == OPC_SYSTEM && rand_bits(2) == 0) begin
                w[19:7] = '0;
                case (3'(rand_bits(3)))
                    3'd0:    w[31:20] = 12'h000;
                    3'd1:    w[31:20] = 12'h001;
                    3'd2:    w[31:20] = 12'h102;
                    3'd3:    w[31:20] = 12'h302;
                    default: w[31:20] = 12'h105;
                endcase
            end
            if (next_bit()) begin
                w[19:15] = last_rd;
            end
            if (rand_bits(2) == 0) begin
                w[24:20] = last_rd;
            end
        end
        last_rd = w[11:7];
        return w;
    endfunction

    ////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////

    function automatic op_e ref_op(input word_t w);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        op_e        op;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        op  = INVALID;
        case (opc)
            OPC_LUI:   op = LUI;
            // AUIPC issues as ADD with the PC as first operand
            OPC_AUIPC: op = ADD;
            OPC_JAL:   op = JAL;
            OPC_JALR: begin
                if (f3 == 3'd0) begin
                    op = JALR;
                end
            end
            OPC_BRANCH: begin
                case (f3)
                    3'd0: op = BEQ;
                    3'd1: op = BNE;
                    3'd4: op = BLT;
                    3'd5: op = BGE;
                    3'd6: op = BLTU;
                    3'd7: op = BGEU;
                    default: ;
                endcase
            end
            OPC_LOAD: begin
                case (f3)
                    3'd0: op = LB;
                    3'd1: op = LH;
                    3'd2: op = LW;
                    3'd4: op = LBU;
                    3'd5: op = LHU;
                    default: ;
                endcase
            end
            OPC_STORE: begin
                case (f3)
                    3'd0: op = SB;
                    3'd1: op = SH;
                    3'd2: op = SW;
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                case (f3)
                    3'd0: op = ADD;
                    3'd1: op = (f7 == 7'h00) ? SLL : INVALID;
                    3'd2: op = SLT;
                    3'd3: op = SLTU;
                    3'd4: op = XOR;
                    3'd5: op = (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
                    3'd6: op = OR;
                    default: op = AND;
                endcase
            end
            OPC_OP: begin
                if (f7 == 7'h00) begin
                    case (f3)
                        3'd0: op = ADD;
                        3'd1: op = SLL;
                        3'd2: op = SLT;
                        3'd3: op = SLTU;
                        3'd4: op = XOR;
                        3'd5: op = SRL;
                        3'd6: op = OR;
                        default: op = AND;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd0) begin
                    op = SUB;
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    op = SRA;
                end
            end
            OPC_MISC_MEM: begin
                if (f3 == 3'd0) begin
                    op = NOP;
                end
            end
            OPC_SYSTEM: begin
                case (f3)
                    3'd0: begin
                        if (w[19:7] == '0) begin
                            case (w[31:20])
                                12'h000: op = ECALL;
                                12'h001: op = EBREAK;
                                12'h102: op = SRET;
                                12'h302: op = MRET;
                                12'h105: op = WFI;
                                default: ;
                            endcase
                        end
                    end
                    3'd1: op = CSRRW;
                    3'd2: op = CSRRS;
                    3'd3: op = CSRRC;
                    3'd5: op = CSRRWI;
                    3'd6: op = CSRRSI;
                    3'd7: op = CSRRCI;
                    default: ;
                endcase
            end
            default: ;
        endcase
        return op;
    endfunction

    function automatic format_e ref_format(input word_t w);
        case (w[6:0])
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return I_TYPE;
            OPC_STORE:                      return S_TYPE;
            OPC_BRANCH:                     return B_TYPE;
            OPC_LUI, OPC_AUIPC:             return U_TYPE;
            OPC_JAL:                        return J_TYPE;
            default:                        return R_TYPE;
        endcase
    endfunction

    function automatic word_t ref_imm(input word_t w, input format_e f);
        case (f)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////

    initial begin
        word_t     m_last;
        logic      m_replay;
        reg_addr_t m_lock_reg;
        logic      m_lock_mem;
        word_t     eff;
        op_e       op;
        format_e   fmt;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use1;
        logic      use2;
        logic      mem;
        logic      hz;
        int        issued;

        lfsr_state = 32'd19;
        for (int i = 0; i < 32; i++) begin
            bank[i] = rand_bits(32);
        end
        clk        = 1'b0;
        reset      = 1'b1;
        stall_i    = 1'b0;
        instr_i    = '0;
        pc_i       = '0;
        last_rd    = '0;
        m_last     = '0;
        m_replay   = 1'b0;
        m_lock_reg = '0;
        m_lock_mem = 1'b0;
        issued     = 0;
        expect_bubble();

        repeat (3) @(posedge clk);

        while (issued < NUM_INSTR) begin
            @(negedge clk);
            // First pass sees the reset values
            check_outputs();
            reset   = 1'b0;
            stall_i = (rand_bits(3) == 0);
            instr_i = gen_instr();
            if (!m_replay) begin
                pc_i = rand_bits(32);
                if (rand_bits(2) != 0) begin
                    pc_i[1:0] = 2'b00;
                end
            end
            #1;

            eff  = m_replay ? m_last : instr_i;
            op   = ref_op(eff);
            fmt  = ref_format(eff);
            imm  = ref_imm(eff, fmt);
            rs1  = eff[19:15];
            rs2  = eff[24:20];
            use1 = fmt inside {R_TYPE, I_TYPE, S_TYPE, B_TYPE};
            use2 = fmt inside {R_TYPE, S_TYPE, B_TYPE};
            mem  = (eff[6:0] == OPC_LOAD) || (eff[6:0] == OPC_STORE);
            hz   = !stall_i && ((m_lock_mem && mem)
                   || (use1 && rs1 == m_lock_reg && rs1 != 5'd0)
                   || (use2 && rs2 == m_lock_reg && rs2 != 5'd0));

            check_flag("hazard_o", hz, hazard_o);
            check_addr("rs1_addr_o", rs1, rs1_addr_o);
            check_addr("rs2_addr_o", rs2, rs2_addr_o);

            if (hz) begin
                expect_bubble();
                m_lock_reg = '0;
                m_lock_mem = 1'b0;
            end else if (!stall_i) begin
                exp_op         = op;
                exp_rd         = eff[11:7];
                exp_pc         = pc_i;
                exp_illegal    = (op == INVALID);
                exp_misaligned = (pc_i[1:0] != 2'b00);
                case (fmt)
                    U_TYPE, J_TYPE: begin
                        exp_first  = pc_i;
                        exp_second = imm;
                        exp_third  = imm;
                    end
                    R_TYPE, B_TYPE: begin
                        exp_first  = bank[rs1];
                        exp_second = bank[rs2];
                        exp_third  = imm;
                    end
                    S_TYPE: begin
                        exp_first  = bank[rs1];
                        exp_second = imm;
                        exp_third  = bank[rs2];
                    end
                    default: begin
                        exp_first  = bank[rs1];
                        exp_second = imm;
                        exp_third  = imm;
                    end
                endcase
                m_lock_reg = eff[11:7];
                m_lock_mem = (eff[6:0] == OPC_STORE);
                issued++;
            end
            m_replay = hz || stall_i;
            m_last   = eff;
        end

        // Last accepted instruction
        @(negedge clk);
        check_outputs();
        $display("No errors");
        $finish;
    end

endmodule

// File: files.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/decode_if.sv
src/instr_decoder.sv
src/hazard_unit.sv
src/decode_stage.sv
testbench/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_decode_stage -o tb_decode_stage \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_decode_stage > sim.log 2>&1
grep -q "Errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "No errors" sim.log && echo "Simulation passed" || { echo "Simulation incomplete"; exit 1; }
